//--- rtl/exec_pkg.sv
package exec_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [16:0] opcode_t;    // {major, funct3, funct7}
    typedef logic [3:0]  strb_t;
    typedef logic [6:0]  major_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [4:0]  shamt_t;

    localparam major_t OP_REG    = 7'b0110011;
    localparam major_t OP_IMM    = 7'b0010011;
    localparam major_t OP_LUI    = 7'b0110111;
    localparam major_t OP_AUIPC  = 7'b0010111;
    localparam major_t OP_JAL    = 7'b1101111;
    localparam major_t OP_JALR   = 7'b1100111;
    localparam major_t OP_BRANCH = 7'b1100011;
    localparam major_t OP_LOAD   = 7'b0000011;
    localparam major_t OP_STORE  = 7'b0100011;

    localparam funct7_t F7_ZERO = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;    // sub, sra, srai

    // alu group
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;
    localparam funct3_t F3_JALR = 3'b000;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // access sizes
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    localparam strb_t STRB_BYTE = 4'b0001;
    localparam strb_t STRB_HALF = 4'b0011;
    localparam strb_t STRB_WORD = 4'b1111;

    localparam xlen_t INSTR_BYTES = 32'd4;

    function automatic major_t op_major(opcode_t op);
        return op[16:10];
    endfunction

    function automatic funct3_t op_funct3(opcode_t op);
        return op[9:7];
    endfunction

    function automatic funct7_t op_funct7(opcode_t op);
        return op[6:0];
    endfunction

    function automatic xlen_t imm_i(xlen_t imm);
        return {{20{imm[11]}}, imm[11:0]};
    endfunction

    function automatic xlen_t imm_b(xlen_t imm);
        return {{19{imm[12]}}, imm[12:1], 1'b0};
    endfunction

    function automatic xlen_t imm_u(xlen_t imm);
        return {imm[31:12], 12'b0};
    endfunction

endpackage

//--- rtl/exec_capture.sv
module exec_capture (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                stall,
    input  logic                mem_wait,
    input  exec_pkg::xlen_t     pc,
    input  exec_pkg::opcode_t   opcode,
    input  exec_pkg::reg_addr_t rd_addr,
    input  exec_pkg::xlen_t     rs1_data,
    input  exec_pkg::xlen_t     rs2_data,
    input  exec_pkg::xlen_t     imm,
    output exec_pkg::xlen_t     cap_pc,
    output exec_pkg::opcode_t   cap_opcode,
    output exec_pkg::reg_addr_t cap_rd,
    output exec_pkg::xlen_t     cap_rs1,
    output exec_pkg::xlen_t     cap_rs2,
    output exec_pkg::xlen_t     cap_imm
);
    import exec_pkg::*;

    logic bubble;
    logic load;

    // flush beats mem_wait, mem_wait beats stall
    assign bubble = !rst_n || flush || (stall && !mem_wait);
    assign load   = !mem_wait;

    always_ff @(posedge CLK) begin
        if (bubble) begin
            cap_pc     <= '0;
            cap_opcode <= '0;    // zero key decodes as nothing
            cap_rd     <= '0;
            cap_rs1    <= '0;
            cap_rs2    <= '0;
            cap_imm    <= '0;
        end else if (load) begin
            cap_pc     <= pc;
            cap_opcode <= opcode;
            cap_rd     <= rd_addr;
            cap_rs1    <= rs1_data;
            cap_rs2    <= rs2_data;
            cap_imm    <= imm;
        end
    end

endmodule

//--- rtl/exec_int_unit.sv
module exec_int_unit (
    input  exec_pkg::xlen_t     cap_pc,
    input  exec_pkg::opcode_t   cap_opcode,
    input  exec_pkg::reg_addr_t cap_rd,
    input  exec_pkg::xlen_t     cap_rs1,
    input  exec_pkg::xlen_t     cap_rs2,
    input  exec_pkg::xlen_t     cap_imm,
    output logic                reg_w_en,
    output exec_pkg::reg_addr_t reg_w_rd,
    output exec_pkg::xlen_t     reg_w_data
);
    import exec_pkg::*;

    major_t  major;
    funct3_t funct3;
    funct7_t funct7;
    xlen_t   imm_s;
    shamt_t  shamt_r;
    shamt_t  shamt_i;
    logic    hit;
    xlen_t   result;

    assign major   = op_major(cap_opcode);
    assign funct3  = op_funct3(cap_opcode);
    assign funct7  = op_funct7(cap_opcode);
    assign imm_s   = imm_i(cap_imm);
    assign shamt_r = cap_rs2[4:0];
    assign shamt_i = cap_imm[4:0];

    always_comb begin
        hit    = 1'b1;
        result = '0;
        case (major)
            OP_REG: begin
                case ({funct3, funct7})
                    {F3_ADD, F7_ZERO}:  result = cap_rs1 + cap_rs2;
                    {F3_ADD, F7_ALT}:   result = cap_rs1 - cap_rs2;
                    {F3_SLL, F7_ZERO}:  result = cap_rs1 << shamt_r;
                    {F3_SLT, F7_ZERO}:  result = xlen_t'($signed(cap_rs1) < $signed(cap_rs2));
                    {F3_SLTU, F7_ZERO}: result = xlen_t'(cap_rs1 < cap_rs2);
                    {F3_XOR, F7_ZERO}:  result = cap_rs1 ^ cap_rs2;
                    {F3_SR, F7_ZERO}:   result = cap_rs1 >> shamt_r;
                    {F3_SR, F7_ALT}:    result = $signed(cap_rs1) >>> shamt_r;
                    {F3_OR, F7_ZERO}:   result = cap_rs1 | cap_rs2;
                    {F3_AND, F7_ZERO}:  result = cap_rs1 & cap_rs2;
                    default:            hit = 1'b0;
                endcase
            end
            OP_IMM: begin
                case (funct3)
                    F3_ADD:  result = cap_rs1 + imm_s;
                    F3_SLT:  result = xlen_t'($signed(cap_rs1) < $signed(imm_s));
                    F3_SLTU: result = xlen_t'(cap_rs1 < imm_s);    // compare sign-extended imm
                    F3_XOR:  result = cap_rs1 ^ imm_s;
                    F3_OR:   result = cap_rs1 | imm_s;
                    F3_AND:  result = cap_rs1 & imm_s;
                    F3_SLL: begin
                        hit    = (funct7 == F7_ZERO);
                        result = cap_rs1 << shamt_i;
                    end
                    F3_SR: begin
                        hit = (funct7 == F7_ZERO) || (funct7 == F7_ALT);
                        if (funct7 == F7_ALT) begin
                            result = $signed(cap_rs1) >>> shamt_i;
                        end else begin
                            result = cap_rs1 >> shamt_i;
                        end
                    end
                    default: hit = 1'b0;
                endcase
            end
            OP_LUI: begin
                result = imm_u(cap_imm);
            end
            OP_AUIPC: begin
                result = cap_pc + imm_u(cap_imm);
            end
            OP_JAL: begin
                result = cap_pc + INSTR_BYTES;    // link
            end
            OP_JALR: begin
                hit    = (funct3 == F3_JALR);
                result = cap_pc + INSTR_BYTES;
            end
            default: begin
                hit = 1'b0;
            end
        endcase
    end

    // loads write back later, so no request here
    assign reg_w_en   = hit;
    assign reg_w_rd   = hit ? cap_rd : '0;
    assign reg_w_data = hit ? result : '0;

endmodule

//--- rtl/exec_mem_unit.sv
module exec_mem_unit (
    input  exec_pkg::opcode_t   cap_opcode,
    input  exec_pkg::reg_addr_t cap_rd,
    input  exec_pkg::xlen_t     cap_rs1,
    input  exec_pkg::xlen_t     cap_rs2,
    input  exec_pkg::xlen_t     cap_imm,
    output logic                mem_r_en,
    output exec_pkg::reg_addr_t mem_r_rd,
    output exec_pkg::xlen_t     mem_r_addr,
    output exec_pkg::strb_t     mem_r_strb,
    output logic                mem_r_signed,
    output logic                mem_w_en,
    output exec_pkg::xlen_t     mem_w_addr,
    output exec_pkg::strb_t     mem_w_strb,
    output exec_pkg::xlen_t     mem_w_data
);
    import exec_pkg::*;

    major_t  major;
    funct3_t funct3;
    xlen_t   eff_addr;
    strb_t   size_strb;
    logic    size_signed;
    logic    ld_ok;
    logic    st_ok;
    logic    rd_en;
    logic    wr_en;

    assign major    = op_major(cap_opcode);
    assign funct3   = op_funct3(cap_opcode);
    assign eff_addr = cap_rs1 + imm_i(cap_imm);

    // size decode shared by loads and stores
    always_comb begin
        size_strb   = '0;
        size_signed = 1'b0;
        ld_ok       = 1'b1;
        st_ok       = 1'b1;
        case (funct3)
            F3_B: begin
                size_strb   = STRB_BYTE;
                size_signed = 1'b1;
            end
            F3_H: begin
                size_strb   = STRB_HALF;
                size_signed = 1'b1;
            end
            F3_W: begin
                size_strb = STRB_WORD;
            end
            F3_BU: begin
                size_strb = STRB_BYTE;
                st_ok     = 1'b0;    // no unsigned store
            end
            F3_HU: begin
                size_strb = STRB_HALF;
                st_ok     = 1'b0;
            end
            default: begin
                ld_ok = 1'b0;
                st_ok = 1'b0;
            end
        endcase
    end

    assign rd_en = (major == OP_LOAD) && ld_ok;
    assign wr_en = (major == OP_STORE) && st_ok;

    assign mem_r_en     = rd_en;
    assign mem_r_rd     = rd_en ? cap_rd : '0;
    assign mem_r_addr   = rd_en ? eff_addr : '0;
    assign mem_r_strb   = rd_en ? size_strb : '0;
    assign mem_r_signed = rd_en && size_signed;    // lb, lh only

    assign mem_w_en   = wr_en;
    assign mem_w_addr = wr_en ? eff_addr : '0;
    assign mem_w_strb = wr_en ? size_strb : '0;
    assign mem_w_data = wr_en ? cap_rs2 : '0;

endmodule

//--- rtl/exec_branch_unit.sv
module exec_branch_unit (
    input  exec_pkg::xlen_t   cap_pc,
    input  exec_pkg::opcode_t cap_opcode,
    input  exec_pkg::xlen_t   cap_rs1,
    input  exec_pkg::xlen_t   cap_rs2,
    input  exec_pkg::xlen_t   cap_imm,
    output logic              jmp_do,
    output exec_pkg::xlen_t   jmp_pc
);
    import exec_pkg::*;

    major_t  major;
    funct3_t funct3;
    xlen_t   br_sum;
    xlen_t   jr_sum;
    xlen_t   br_target;
    xlen_t   jr_target;
    logic    br_valid;
    logic    br_taken;
    logic    jr_valid;

    assign major  = op_major(cap_opcode);
    assign funct3 = op_funct3(cap_opcode);
    assign br_sum = cap_pc + imm_b(cap_imm);
    assign jr_sum = cap_rs1 + imm_i(cap_imm);

    // both targets halfword aligned
    assign br_target = {br_sum[31:1], 1'b0};
    assign jr_target = {jr_sum[31:1], 1'b0};
    assign jr_valid  = (funct3 == F3_JALR);

    always_comb begin
        br_valid = 1'b1;
        br_taken = 1'b0;
        case (funct3)
            F3_BEQ:  br_taken = (cap_rs1 == cap_rs2);
            F3_BNE:  br_taken = (cap_rs1 != cap_rs2);
            F3_BLT:  br_taken = ($signed(cap_rs1) < $signed(cap_rs2));
            F3_BGE:  br_taken = ($signed(cap_rs1) >= $signed(cap_rs2));
            F3_BLTU: br_taken = (cap_rs1 < cap_rs2);
            F3_BGEU: br_taken = (cap_rs1 >= cap_rs2);
            default: br_valid = 1'b0;
        endcase
    end

    always_comb begin
        case (major)
            OP_BRANCH: begin
                jmp_do = br_valid && br_taken;
                jmp_pc = br_valid ? br_target : '0;    // target shown even when not taken
            end
            OP_JAL: begin
                jmp_do = 1'b1;
                jmp_pc = br_target;
            end
            OP_JALR: begin
                jmp_do = jr_valid;
                jmp_pc = jr_valid ? jr_target : '0;
            end
            default: begin
                jmp_do = 1'b0;
                jmp_pc = '0;
            end
        endcase
    end

endmodule

//--- rtl/exec_stage.sv
module exec_stage (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                stall,
    input  logic                mem_wait,
    input  exec_pkg::xlen_t     pc,
    input  exec_pkg::opcode_t   opcode,
    input  exec_pkg::reg_addr_t rd_addr,
    input  exec_pkg::xlen_t     rs1_data,
    input  exec_pkg::xlen_t     rs2_data,
    input  exec_pkg::xlen_t     imm,
    output exec_pkg::xlen_t     exec_pc,
    output logic                reg_w_en,
    output exec_pkg::reg_addr_t reg_w_rd,
    output exec_pkg::xlen_t     reg_w_data,
    output logic                mem_r_en,
    output exec_pkg::reg_addr_t mem_r_rd,
    output exec_pkg::xlen_t     mem_r_addr,
    output exec_pkg::strb_t     mem_r_strb,
    output logic                mem_r_signed,
    output logic                mem_w_en,
    output exec_pkg::xlen_t     mem_w_addr,
    output exec_pkg::strb_t     mem_w_strb,
    output exec_pkg::xlen_t     mem_w_data,
    output logic                jmp_do,
    output exec_pkg::xlen_t     jmp_pc
);
    import exec_pkg::*;

    xlen_t     cap_pc;
    opcode_t   cap_opcode;
    reg_addr_t cap_rd;
    xlen_t     cap_rs1;
    xlen_t     cap_rs2;
    xlen_t     cap_imm;

    assign exec_pc = cap_pc;

    exec_capture i_capture (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .flush      (flush),
        .stall      (stall),
        .mem_wait   (mem_wait),
        .pc         (pc),
        .opcode     (opcode),
        .rd_addr    (rd_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .cap_pc     (cap_pc),
        .cap_opcode (cap_opcode),
        .cap_rd     (cap_rd),
        .cap_rs1    (cap_rs1),
        .cap_rs2    (cap_rs2),
        .cap_imm    (cap_imm)
    );

    // three peers, all combinational off the capture register
    exec_int_unit i_int (
        .cap_pc     (cap_pc),
        .cap_opcode (cap_opcode),
        .cap_rd     (cap_rd),
        .cap_rs1    (cap_rs1),
        .cap_rs2    (cap_rs2),
        .cap_imm    (cap_imm),
        .reg_w_en   (reg_w_en),
        .reg_w_rd   (reg_w_rd),
        .reg_w_data (reg_w_data)
    );

    exec_mem_unit i_mem (
        .cap_opcode   (cap_opcode),
        .cap_rd       (cap_rd),
        .cap_rs1      (cap_rs1),
        .cap_rs2      (cap_rs2),
        .cap_imm      (cap_imm),
        .mem_r_en     (mem_r_en),
        .mem_r_rd     (mem_r_rd),
        .mem_r_addr   (mem_r_addr),
        .mem_r_strb   (mem_r_strb),
        .mem_r_signed (mem_r_signed),
        .mem_w_en     (mem_w_en),
        .mem_w_addr   (mem_w_addr),
        .mem_w_strb   (mem_w_strb),
        .mem_w_data   (mem_w_data)
    );

    exec_branch_unit i_branch (
        .cap_pc     (cap_pc),
        .cap_opcode (cap_opcode),
        .cap_rs1    (cap_rs1),
        .cap_rs2    (cap_rs2),
        .cap_imm    (cap_imm),
        .jmp_do     (jmp_do),
        .jmp_pc     (jmp_pc)
    );

endmodule

//--- sim/exec_stage_asserts.sv
module exec_stage_asserts (
    input logic            CLK,
    input logic            rst_n,
    input logic            reg_w_en,
    input logic            mem_r_en,
    input logic            mem_w_en,
    input logic            jmp_do,
    input exec_pkg::xlen_t jmp_pc
);

    int unsigned fail_count = 0;    // failed properties so far

    // a load and a store never leave together
    mem_excl: assert property (@(posedge CLK) disable iff (!rst_n)
        !(mem_r_en && mem_w_en))
        else begin
            $error("load and store request in the same cycle");
            fail_count++;
        end

    // stores never write the register file
    store_no_wb: assert property (@(posedge CLK) disable iff (!rst_n)
        !(reg_w_en && mem_w_en))
        else begin
            $error("register write-back together with a store");
            fail_count++;
        end

    jump_aligned: assert property (@(posedge CLK) disable iff (!rst_n)
        jmp_do |-> (jmp_pc[0] == 1'b0))
        else begin
            $error("jump target with bit 0 set");
            fail_count++;
        end

endmodule

bind exec_stage exec_stage_asserts i_asserts (.*);

//--- sim/tb_exec_stage.sv
module tb_exec_stage;
    import exec_pkg::*;

    typedef logic [214:0] out_vec_t;    // all outputs side by side

    localparam int DRAIN_LIMIT = 20;

    logic      CLK;
    logic      rst_n;
    logic      flush;
    logic      stall;
    logic      mem_wait;
    xlen_t     pc;
    opcode_t   opcode;
    reg_addr_t rd_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     imm;

    xlen_t     exec_pc;
    logic      reg_w_en;
    reg_addr_t reg_w_rd;
    xlen_t     reg_w_data;
    logic      mem_r_en;
    reg_addr_t mem_r_rd;
    xlen_t     mem_r_addr;
    strb_t     mem_r_strb;
    logic      mem_r_signed;
    logic      mem_w_en;
    xlen_t     mem_w_addr;
    strb_t     mem_w_strb;
    xlen_t     mem_w_data;
    logic      jmp_do;
    xlen_t     jmp_pc;

    // expected contents of the capture register
    xlen_t     m_pc;
    opcode_t   m_op;
    reg_addr_t m_rd;
    xlen_t     m_rs1;
    xlen_t     m_rs2;
    xlen_t     m_imm;

    out_vec_t    exp_q[$];
    string       name_q[$];
    out_vec_t    act_vec;
    out_vec_t    cmp_exp;
    string       cmp_name;

    xlen_t      edges [3] = '{32'h0000_0000, 32'h8000_0000, 32'hFFFF_FFFF};
    logic [2:0] r_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic [6:0] r_f7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
    logic [2:0] i_f3 [6]  = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
    logic [2:0] b_f3 [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [2:0] l_f3 [5]  = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};

    exec_stage i_dut (.*);

    assign act_vec = {exec_pc, reg_w_en, reg_w_rd, reg_w_data,
                      mem_r_en, mem_r_rd, mem_r_addr, mem_r_strb, mem_r_signed,
                      mem_w_en, mem_w_addr, mem_w_strb, mem_w_data, jmp_do, jmp_pc};

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic opcode_t make_key(logic [6:0] maj, logic [2:0] f3, logic [6:0] f7);
        return {maj, f3, f7};
    endfunction

    function automatic xlen_t shift_right(xlen_t v, logic [4:0] sh, logic arith);
        xlen_t fill;
        fill = (arith && v[31]) ? ~(32'hFFFF_FFFF >> sh) : 32'h0;    // sign bits on top
        return (v >> sh) | fill;
    endfunction

    function automatic out_vec_t ref_outputs(xlen_t p, opcode_t op, reg_addr_t rd,
                                             xlen_t a, xlen_t b, xlen_t im);
        logic [6:0] maj;
        logic [2:0] f3;
        logic [6:0] f7;
        xlen_t      i_ext;
        xlen_t      b_ext;
        xlen_t      u_val;
        xlen_t      ea;
        logic       w_en;
        xlen_t      w_data;
        logic       r_en;
        strb_t      r_strb;
        logic       r_sgn;
        logic       s_en;
        strb_t      s_strb;
        logic       j_do;
        xlen_t      j_pc;
        maj    = op[16:10];
        f3     = op[9:7];
        f7     = op[6:0];
        i_ext  = {{20{im[11]}}, im[11:0]};
        b_ext  = {{19{im[12]}}, im[12:1], 1'b0};
        u_val  = {im[31:12], 12'h000};
        ea     = a + i_ext;
        w_en   = 1'b0;
        w_data = '0;
        r_en   = 1'b0;
        r_strb = '0;
        r_sgn  = 1'b0;
        s_en   = 1'b0;
        s_strb = '0;
        j_do   = 1'b0;
        j_pc   = '0;
        if (maj == OP_REG) begin
            w_en = 1'b1;
            case ({f7, f3})
                {7'h00, 3'd0}: w_data = a + b;
                {F7_ALT, 3'd0}: w_data = a - b;
                {7'h00, 3'd1}: w_data = a << b[4:0];
                {7'h00, 3'd2}: w_data = {31'b0, $signed(a) < $signed(b)};
                {7'h00, 3'd3}: w_data = {31'b0, a < b};
                {7'h00, 3'd4}: w_data = a ^ b;
                {7'h00, 3'd5}: w_data = shift_right(a, b[4:0], 1'b0);
                {F7_ALT, 3'd5}: w_data = shift_right(a, b[4:0], 1'b1);
                {7'h00, 3'd6}: w_data = a | b;
                {7'h00, 3'd7}: w_data = a & b;
                default: w_en = 1'b0;
            endcase
        end else if (maj == OP_IMM) begin
            w_en = 1'b1;
            case (f3)
                3'd0: w_data = a + i_ext;
                3'd2: w_data = {31'b0, $signed(a) < $signed(i_ext)};
                3'd3: w_data = {31'b0, a < i_ext};
                3'd4: w_data = a ^ i_ext;
                3'd6: w_data = a | i_ext;
                3'd7: w_data = a & i_ext;
                3'd1: begin
                    w_en   = (f7 == 7'h00);
                    w_data = a << im[4:0];
                end
                default: begin    // srli or srai
                    w_en   = (f7 == 7'h00) || (f7 == F7_ALT);
                    w_data = shift_right(a, im[4:0], f7 == F7_ALT);
                end
            endcase
        end else if (maj == OP_LUI) begin
            w_en   = 1'b1;
            w_data = u_val;
        end else if (maj == OP_AUIPC) begin
            w_en   = 1'b1;
            w_data = p + u_val;
        end else if (maj == OP_JAL) begin
            w_en   = 1'b1;
            w_data = p + INSTR_BYTES;
            j_do   = 1'b1;
            j_pc   = (p + b_ext) & 32'hFFFF_FFFE;
        end else if (maj == OP_JALR && f3 == 3'd0) begin
            w_en   = 1'b1;
            w_data = p + INSTR_BYTES;
            j_do   = 1'b1;
            j_pc   = ea & 32'hFFFF_FFFE;
        end else if (maj == OP_LOAD) begin
            r_en = 1'b1;
            case (f3)
                3'd0: {r_strb, r_sgn} = {STRB_BYTE, 1'b1};
                3'd1: {r_strb, r_sgn} = {STRB_HALF, 1'b1};
                3'd2: r_strb = STRB_WORD;
                3'd4: r_strb = STRB_BYTE;
                3'd5: r_strb = STRB_HALF;
                default: r_en = 1'b0;
            endcase
        end else if (maj == OP_STORE) begin
            s_en = (f3 <= 3'd2);
            s_strb = (f3 == 3'd0) ? STRB_BYTE : (f3 == 3'd1) ? STRB_HALF : STRB_WORD;
        end else if (maj == OP_BRANCH && f3 != 3'd2 && f3 != 3'd3) begin
            j_pc = (p + b_ext) & 32'hFFFF_FFFE;    // shown even if not taken
            case (f3)
                3'd0: j_do = (a == b);
                3'd1: j_do = (a != b);
                3'd4: j_do = $signed(a) < $signed(b);
                3'd5: j_do = !($signed(a) < $signed(b));
                3'd6: j_do = a < b;
                default: j_do = !(a < b);
            endcase
        end
        return {p, w_en, w_en ? rd : 5'd0, w_en ? w_data : 32'd0,
                r_en, r_en ? rd : 5'd0, r_en ? ea : 32'd0, r_en ? r_strb : 4'd0, r_en && r_sgn,
                s_en, s_en ? ea : 32'd0, s_en ? s_strb : 4'd0, s_en ? b : 32'd0, j_do, j_pc};
    endfunction

    task automatic check_value(input string name, input out_vec_t exp_v, input out_vec_t act_v);
        if (exp_v !== act_v) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp_v, act_v);
            $display("Regression failed");
            $fatal(1, "output mismatch in %s", name);
        end
    endtask

    task automatic drive_cycle(input string name, input logic rst, input logic fl,
                               input logic st, input logic mw, input xlen_t p,
                               input opcode_t op, input reg_addr_t rd,
                               input xlen_t a, input xlen_t b, input xlen_t im);
        @(negedge CLK);
        rst_n    = rst;
        flush    = fl;
        stall    = st;
        mem_wait = mw;
        pc       = p;
        opcode   = op;
        rd_addr  = rd;
        rs1_data = a;
        rs2_data = b;
        imm      = im;
        if (!rst || fl) begin
            {m_pc, m_op, m_rd, m_rs1, m_rs2, m_imm} = '0;
        end else if (mw) begin
            // hold
        end else if (st) begin
            {m_pc, m_op, m_rd, m_rs1, m_rs2, m_imm} = '0;    // bubble
        end else begin
            {m_pc, m_op, m_rd, m_rs1, m_rs2, m_imm} = {p, op, rd, a, b, im};
        end
        exp_q.push_back(ref_outputs(m_pc, m_op, m_rd, m_rs1, m_rs2, m_imm));
        name_q.push_back(name);
    endtask

    task automatic run_op(input string name, input opcode_t op, input xlen_t a,
                          input xlen_t b, input xlen_t im);
        xlen_t     p;
        reg_addr_t rd;
        p  = $urandom() & 32'hFFFF_FFFC;
        rd = $urandom_range(31, 0);
        drive_cycle(name, 1'b1, 1'b0, 1'b0, 1'b0, p, op, rd, a, b, im);
    endtask

    // outputs settle right after the capture edge
    always @(posedge CLK) begin
        if (exp_q.size() > 0) begin
            cmp_exp  = exp_q.pop_front();
            cmp_name = name_q.pop_front();
            #1;
            check_value(cmp_name, cmp_exp, act_vec);
        end
    end

    // a failed property in the bound checker ends the run
    always @(posedge CLK) begin
        #2;
        if (i_dut.i_asserts.fail_count != 0) begin
            $display("a property on the DUT outputs was violated");
            $display("Regression failed");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        int unsigned k;
        xlen_t       a;
        xlen_t       b;
        int          drain;
        void'($urandom(32'h6e5c));
        {rst_n, flush, stall, mem_wait} = 4'b0000;
        {pc, opcode, rd_addr, rs1_data, rs2_data, imm} = '0;
        {m_pc, m_op, m_rd, m_rs1, m_rs2, m_imm} = '0;

        repeat (3) begin
            drive_cycle("reset", 1'b0, 1'b0, 1'b0, 1'b0, $urandom(), make_key(OP_REG, 3'd0, 7'h00),
                        5'd3, $urandom(), $urandom(), $urandom());
        end

        for (int n = 0; n < 40; n++) begin
            k = $urandom_range(9, 0);
            run_op("alu_reg", make_key(OP_REG, r_f3[k], r_f7[k]), $urandom(), $urandom(), $urandom());
            k = $urandom_range(5, 0);
            run_op("alu_imm", make_key(OP_IMM, i_f3[k], 7'($urandom())), $urandom(), $urandom(),
                   $urandom());
        end

        for (int n = 0; n < 5; n++) begin
            foreach (edges[i]) begin
                foreach (edges[j]) begin
                    a = (n == 0) ? edges[i] : $urandom();    // edge pairs first
                    b = (n == 0) ? edges[j] : $urandom();
                    run_op("sll", make_key(OP_REG, 3'd1, 7'h00), a, b, 32'h0);
                    run_op("srl", make_key(OP_REG, 3'd5, 7'h00), a, b, 32'h0);
                    run_op("sra", make_key(OP_REG, 3'd5, F7_ALT), a, b, 32'h0);
                    run_op("slt", make_key(OP_REG, 3'd2, 7'h00), a, b, 32'h0);
                    run_op("sltu", make_key(OP_REG, 3'd3, 7'h00), a, b, 32'h0);
                    run_op("slti", make_key(OP_IMM, 3'd2, 7'h00), a, 32'h0, b);
                    run_op("sltiu", make_key(OP_IMM, 3'd3, 7'h00), a, 32'h0, b);
                    run_op("slli", make_key(OP_IMM, 3'd1, 7'h00), a, 32'h0, b);
                    run_op("srli", make_key(OP_IMM, 3'd5, 7'h00), a, 32'h0, b);
                    run_op("srai", make_key(OP_IMM, 3'd5, F7_ALT), a, 32'h0, b);
                    run_op("lui", make_key(OP_LUI, 3'd0, 7'h00), a, 32'h0, b);
                    run_op("auipc", make_key(OP_AUIPC, 3'd0, 7'h00), a, 32'h0, b);
                end
            end
        end

        foreach (l_f3[i]) begin
            repeat (4) run_op("load", make_key(OP_LOAD, l_f3[i], 7'h00), $urandom(), $urandom(),
                              $urandom());
        end
        for (int s = 0; s < 3; s++) begin
            repeat (4) run_op("store", make_key(OP_STORE, 3'(s), 7'h00), $urandom(), $urandom(),
                              $urandom());
        end

        foreach (b_f3[i]) begin
            a = $urandom();
            run_op("branch_eq", make_key(OP_BRANCH, b_f3[i], 7'h00), a, a, $urandom());
            run_op("branch_lt", make_key(OP_BRANCH, b_f3[i], 7'h00), 32'h5, 32'h9, $urandom());
            run_op("branch_gt", make_key(OP_BRANCH, b_f3[i], 7'h00), 32'h9, 32'h5, $urandom());
            run_op("branch_neg", make_key(OP_BRANCH, b_f3[i], 7'h00), 32'hFFFF_FFF0, 32'h10,
                   $urandom());
            run_op("branch_pos", make_key(OP_BRANCH, b_f3[i], 7'h00), 32'h10, 32'hFFFF_FFF0,
                   $urandom());
        end
        repeat (6) begin
            run_op("jal", make_key(OP_JAL, 3'($urandom()), 7'($urandom())), $urandom(), $urandom(),
                   $urandom());
            run_op("jalr", make_key(OP_JALR, 3'd0, 7'h00), $urandom(), $urandom(), $urandom());
        end

        run_op("pre_stall", make_key(OP_REG, 3'd0, 7'h00), $urandom(), $urandom(), 32'h0);
        drive_cycle("stall", 1'b1, 1'b0, 1'b1, 1'b0, 32'h100, make_key(OP_STORE, 3'd2, 7'h00),
                    5'd7, $urandom(), $urandom(), $urandom());
        run_op("pre_wait", make_key(OP_LOAD, 3'd2, 7'h00), $urandom(), $urandom(), $urandom());
        repeat (4) begin
            drive_cycle("mem_wait", 1'b1, 1'b0, 1'($urandom()), 1'b1, $urandom(),
                        make_key(OP_JAL, 3'd0, 7'h00), 5'd9, $urandom(), $urandom(), $urandom());
        end
        drive_cycle("flush_in_wait", 1'b1, 1'b1, 1'b0, 1'b1, $urandom(),
                    make_key(OP_REG, 3'd7, 7'h00), 5'd4, $urandom(), $urandom(), $urandom());
        run_op("after_flush", make_key(OP_IMM, 3'd4, 7'h00), $urandom(), $urandom(), $urandom());

        run_op("bad_system", make_key(7'b1110011, 3'd0, 7'h00), $urandom(), $urandom(), $urandom());
        run_op("bad_funct7", make_key(OP_REG, 3'd0, 7'h01), $urandom(), $urandom(), $urandom());
        run_op("bad_slli", make_key(OP_IMM, 3'd1, F7_ALT), $urandom(), $urandom(), $urandom());
        run_op("bad_load", make_key(OP_LOAD, 3'd3, 7'h00), $urandom(), $urandom(), $urandom());
        run_op("bad_store", make_key(OP_STORE, 3'd4, 7'h00), $urandom(), $urandom(), $urandom());
        run_op("bad_branch", make_key(OP_BRANCH, 3'd2, 7'h00), $urandom(), $urandom(), $urandom());
        run_op("bad_jalr", make_key(OP_JALR, 3'd1, 7'h00), $urandom(), $urandom(), $urandom());
        run_op("bad_all_ones", 17'h1FFFF, $urandom(), $urandom(), $urandom());

        drain = 0;
        while (exp_q.size() != 0 && drain < DRAIN_LIMIT) begin
            @(negedge CLK);
            drain++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout waiting for the last outputs to be compared");
            $display("Regression failed");
            $fatal(1, "compare queue did not drain");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

//--- vlog.f
rtl/exec_pkg.sv
rtl/exec_capture.sv
rtl/exec_int_unit.sv
rtl/exec_mem_unit.sv
rtl/exec_branch_unit.sv
rtl/exec_stage.sv
sim/exec_stage_asserts.sv
sim/tb_exec_stage.sv
